// File: logic/fsctl_pkg.sv
package fsctl_pkg;

	// host bus
	localparam int data_width    = 32;
	localparam int reg_idx_width = 8;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	localparam bit [reg_idx_width-1:0] reg_ctrl      = 8'd0;
	localparam bit [reg_idx_width-1:0] reg_l1_base   = 8'd1;
	localparam bit [reg_idx_width-1:0] reg_l2_base   = 8'd6;
	localparam bit [reg_idx_width-1:0] reg_frame_cnt = 8'd11;
	localparam bit [reg_idx_width-1:0] reg_version   = 8'd255;

	// geometry registers per layer
	localparam bit [reg_idx_width-1:0] geo_regs = 8'd5;

	// offsets inside one layer block
	localparam int geo_src_size = 0;
	localparam int geo_win_org  = 1;
	localparam int geo_win_size = 2;
	localparam int geo_dst_org  = 3;
	localparam int geo_dst_size = 4;

	// --------------------------------------------------
	// control register bits
	// --------------------------------------------------
	localparam int ctrl_soft_resetn_bit = 0;
	localparam int ctrl_cfging_bit      = 1;
	localparam int ctrl_order_bit       = 2;
	localparam int ctrl_l1_run_bit      = 5;
	localparam int ctrl_l2_run_bit      = 6;

	// horizontal half of a geometry word, vertical sits at bit 0
	localparam int hi_field_lsb = 16;

endpackage

// File: logic/fsctl_frame_sync.sv
`timescale 1ns/1ns

module fsctl_frame_sync (
	input  logic                            o_clk,
	input  logic                            o_resetn,
	input  logic                            i_fsync,
	output logic                            o_frame_strobe,
	output logic                            o_fsync,
	output logic [fsctl_pkg::data_width-1:0] o_frame_cnt
);

	logic sync_q1;
	logic sync_q2;
	logic sync_prev;

	// two-flop synchronizer plus history for the edge
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			sync_q1   <= 1'b0;
			sync_q2   <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_q1   <= i_fsync;
			sync_q2   <= sync_q1;
			sync_prev <= sync_q2;
		end
	end

	assign o_frame_strobe = sync_q2 & ~sync_prev;

	// fsync pulse lines up with the commit edge
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_fsync     <= 1'b0;
			o_frame_cnt <= '0;
		end else begin
			o_fsync <= o_frame_strobe;
			if (o_frame_strobe)
				o_frame_cnt <= o_frame_cnt + 1'b1;
		end
	end

endmodule

// File: logic/fsctl_layer_stage.sv
`timescale 1ns/1ns

module fsctl_layer_stage #(
	parameter int img_wbits = 12,
	parameter int img_hbits = 12
) (
	input  logic                 o_clk,
	input  logic                 o_resetn,
	input  logic                 i_commit,
	input  logic                 i_run,

	// shadow geometry
	input  logic [img_wbits-1:0] i_src_w,
	input  logic [img_hbits-1:0] i_src_h,
	input  logic [img_wbits-1:0] i_win_left,
	input  logic [img_hbits-1:0] i_win_top,
	input  logic [img_wbits-1:0] i_win_w,
	input  logic [img_hbits-1:0] i_win_h,
	input  logic [img_wbits-1:0] i_dst_left,
	input  logic [img_hbits-1:0] i_dst_top,
	input  logic [img_wbits-1:0] i_dst_w,
	input  logic [img_hbits-1:0] i_dst_h,

	// committed geometry
	output logic [img_wbits-1:0] o_src_w,
	output logic [img_hbits-1:0] o_src_h,
	output logic [img_wbits-1:0] o_win_left,
	output logic [img_hbits-1:0] o_win_top,
	output logic [img_wbits-1:0] o_win_w,
	output logic [img_hbits-1:0] o_win_h,
	output logic [img_wbits-1:0] o_dst_left,
	output logic [img_hbits-1:0] o_dst_top,
	output logic [img_wbits-1:0] o_dst_w,
	output logic [img_hbits-1:0] o_dst_h,
	output logic                 o_soft_resetn
);

	logic [img_wbits-1:0] w_keep;
	logic [img_hbits-1:0] h_keep;
	logic                 size_ok;

	// a stopped layer commits all zeros
	assign w_keep = {img_wbits{i_run}};
	assign h_keep = {img_hbits{i_run}};

	assign size_ok = i_run && (i_src_w != '0) && (i_src_h != '0);

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_src_w       <= '0;
			o_src_h       <= '0;
			o_win_left    <= '0;
			o_win_top     <= '0;
			o_win_w       <= '0;
			o_win_h       <= '0;
			o_dst_left    <= '0;
			o_dst_top     <= '0;
			o_dst_w       <= '0;
			o_dst_h       <= '0;
			o_soft_resetn <= 1'b0;
		end else if (i_commit) begin
			o_src_w       <= i_src_w & w_keep;
			o_src_h       <= i_src_h & h_keep;
			o_win_left    <= i_win_left & w_keep;
			o_win_top     <= i_win_top & h_keep;
			o_win_w       <= i_win_w & w_keep;
			o_win_h       <= i_win_h & h_keep;
			o_dst_left    <= i_dst_left & w_keep;
			o_dst_top     <= i_dst_top & h_keep;
			o_dst_w       <= i_dst_w & w_keep;
			o_dst_h       <= i_dst_h & h_keep;
			// release only with a real source frame
			o_soft_resetn <= size_ok;
		end
	end

endmodule

// File: logic/fsctl_commit.sv
`timescale 1ns/1ns

module fsctl_commit #(
	parameter int img_wbits = 12,
	parameter int img_hbits = 12
) (
	input  logic                 o_clk,
	input  logic                 o_resetn,
	input  logic                 i_frame_strobe,
	input  logic                 i_cfging,
	input  logic                 i_order,
	input  logic                 i_l1_run,
	input  logic                 i_l2_run,

	// shadow geometry, horizontal then vertical
	input  logic [img_wbits-1:0] i_l1_src_w, i_l1_win_left, i_l1_win_w, i_l1_dst_left, i_l1_dst_w,
	input  logic [img_hbits-1:0] i_l1_src_h, i_l1_win_top, i_l1_win_h, i_l1_dst_top, i_l1_dst_h,
	input  logic [img_wbits-1:0] i_l2_src_w, i_l2_win_left, i_l2_win_w, i_l2_dst_left, i_l2_dst_w,
	input  logic [img_hbits-1:0] i_l2_src_h, i_l2_win_top, i_l2_win_h, i_l2_dst_top, i_l2_dst_h,

	output logic                 o_order_1over2,
	output logic                 o_l1_soft_resetn,
	output logic                 o_l2_soft_resetn,
	output logic [img_wbits-1:0] o_l1_src_w, o_l1_win_left, o_l1_win_w, o_l1_dst_left, o_l1_dst_w,
	output logic [img_hbits-1:0] o_l1_src_h, o_l1_win_top, o_l1_win_h, o_l1_dst_top, o_l1_dst_h,
	output logic [img_wbits-1:0] o_l2_src_w, o_l2_win_left, o_l2_win_w, o_l2_dst_left, o_l2_dst_w,
	output logic [img_hbits-1:0] o_l2_src_h, o_l2_win_top, o_l2_win_h, o_l2_dst_top, o_l2_dst_h
);

	logic commit;

	// host hold blocks the whole frame update
	assign commit = i_frame_strobe & ~i_cfging;

	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_order_1over2 <= 1'b0;
		else if (commit)
			o_order_1over2 <= i_order;
	end

	fsctl_layer_stage #(.img_wbits(img_wbits), .img_hbits(img_hbits)) l1_i (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_commit(commit), .i_run(i_l1_run),
		.i_src_w(i_l1_src_w), .i_src_h(i_l1_src_h),
		.i_win_left(i_l1_win_left), .i_win_top(i_l1_win_top),
		.i_win_w(i_l1_win_w), .i_win_h(i_l1_win_h),
		.i_dst_left(i_l1_dst_left), .i_dst_top(i_l1_dst_top),
		.i_dst_w(i_l1_dst_w), .i_dst_h(i_l1_dst_h),
		.o_src_w(o_l1_src_w), .o_src_h(o_l1_src_h),
		.o_win_left(o_l1_win_left), .o_win_top(o_l1_win_top),
		.o_win_w(o_l1_win_w), .o_win_h(o_l1_win_h),
		.o_dst_left(o_l1_dst_left), .o_dst_top(o_l1_dst_top),
		.o_dst_w(o_l1_dst_w), .o_dst_h(o_l1_dst_h),
		.o_soft_resetn(o_l1_soft_resetn)
	);

	fsctl_layer_stage #(.img_wbits(img_wbits), .img_hbits(img_hbits)) l2_i (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_commit(commit), .i_run(i_l2_run),
		.i_src_w(i_l2_src_w), .i_src_h(i_l2_src_h),
		.i_win_left(i_l2_win_left), .i_win_top(i_l2_win_top),
		.i_win_w(i_l2_win_w), .i_win_h(i_l2_win_h),
		.i_dst_left(i_l2_dst_left), .i_dst_top(i_l2_dst_top),
		.i_dst_w(i_l2_dst_w), .i_dst_h(i_l2_dst_h),
		.o_src_w(o_l2_src_w), .o_src_h(o_l2_src_h),
		.o_win_left(o_l2_win_left), .o_win_top(o_l2_win_top),
		.o_win_w(o_l2_win_w), .o_win_h(o_l2_win_h),
		.o_dst_left(o_l2_dst_left), .o_dst_top(o_l2_dst_top),
		.o_dst_w(o_l2_dst_w), .o_dst_h(o_l2_dst_h),
		.o_soft_resetn(o_l2_soft_resetn)
	);

endmodule

// File: logic/fsctl_regbank.sv
`timescale 1ns/1ns

module fsctl_regbank #(
	parameter int                              img_wbits    = 12,
	parameter int                              img_hbits    = 12,
	parameter logic [fsctl_pkg::data_width-1:0] core_version = 32'h0001_0000
) (
	input  logic                               o_clk,
	input  logic                               o_resetn,
	input  logic                               i_wr_en,
	input  logic [fsctl_pkg::reg_idx_width-1:0] i_wr_addr,
	input  logic [fsctl_pkg::data_width-1:0]    i_wr_data,
	input  logic                               i_rd_en,
	input  logic [fsctl_pkg::reg_idx_width-1:0] i_rd_addr,
	input  logic [fsctl_pkg::data_width-1:0]    i_frame_cnt,
	output logic [fsctl_pkg::data_width-1:0]    o_rd_data,

	output logic o_soft_resetn,
	output logic o_cfging,
	output logic o_order,
	output logic o_l1_run,
	output logic o_l2_run,

	output logic [img_wbits-1:0] o_l1_src_w, o_l1_win_left, o_l1_win_w, o_l1_dst_left, o_l1_dst_w,
	output logic [img_hbits-1:0] o_l1_src_h, o_l1_win_top, o_l1_win_h, o_l1_dst_top, o_l1_dst_h,
	output logic [img_wbits-1:0] o_l2_src_w, o_l2_win_left, o_l2_win_w, o_l2_dst_left, o_l2_dst_w,
	output logic [img_hbits-1:0] o_l2_src_h, o_l2_win_top, o_l2_win_h, o_l2_dst_top, o_l2_dst_h
);

	// both layer blocks side by side, layer 2 from geo_regs up
	localparam int geo_num = 2 * fsctl_pkg::geo_regs;
	localparam int geo_aw  = $clog2(geo_num);
	localparam int l2_at   = fsctl_pkg::geo_regs;

	logic [img_wbits-1:0]            geo_hi [geo_num];
	logic [img_hbits-1:0]            geo_lo [geo_num];
	logic                            wr_in_geo;
	logic                            rd_in_geo;
	logic [geo_aw-1:0]               wr_geo;
	logic [geo_aw-1:0]               rd_geo;
	logic [fsctl_pkg::data_width-1:0] rd_word;

	assign wr_in_geo = (i_wr_addr >= fsctl_pkg::reg_l1_base) &&
		(i_wr_addr < fsctl_pkg::reg_l2_base + fsctl_pkg::geo_regs);
	assign rd_in_geo = (i_rd_addr >= fsctl_pkg::reg_l1_base) &&
		(i_rd_addr < fsctl_pkg::reg_l2_base + fsctl_pkg::geo_regs);
	assign wr_geo = geo_aw'(i_wr_addr - fsctl_pkg::reg_l1_base);
	assign rd_geo = geo_aw'(i_rd_addr - fsctl_pkg::reg_l1_base);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= 1'b0;
			o_cfging      <= 1'b0;
			o_order       <= 1'b0;
			o_l1_run      <= 1'b0;
			o_l2_run      <= 1'b0;
		end else if (i_wr_en && i_wr_addr == fsctl_pkg::reg_ctrl) begin
			o_soft_resetn <= i_wr_data[fsctl_pkg::ctrl_soft_resetn_bit];
			o_cfging      <= i_wr_data[fsctl_pkg::ctrl_cfging_bit];
			o_order       <= i_wr_data[fsctl_pkg::ctrl_order_bit];
			o_l1_run      <= i_wr_data[fsctl_pkg::ctrl_l1_run_bit];
			o_l2_run      <= i_wr_data[fsctl_pkg::ctrl_l2_run_bit];
		end
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			for (int i = 0; i < geo_num; i++) begin
				geo_hi[i] <= '0;
				geo_lo[i] <= '0;
			end
		end else if (i_wr_en && wr_in_geo) begin
			geo_hi[wr_geo] <= i_wr_data[fsctl_pkg::hi_field_lsb +: img_wbits];
			geo_lo[wr_geo] <= i_wr_data[0 +: img_hbits];
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	always_comb begin
		rd_word = '0;
		if (i_rd_addr == fsctl_pkg::reg_ctrl) begin
			rd_word[fsctl_pkg::ctrl_soft_resetn_bit] = o_soft_resetn;
			rd_word[fsctl_pkg::ctrl_cfging_bit]      = o_cfging;
			rd_word[fsctl_pkg::ctrl_order_bit]       = o_order;
			rd_word[fsctl_pkg::ctrl_l1_run_bit]      = o_l1_run;
			rd_word[fsctl_pkg::ctrl_l2_run_bit]      = o_l2_run;
		end else if (rd_in_geo) begin
			rd_word[fsctl_pkg::hi_field_lsb +: img_wbits] = geo_hi[rd_geo];
			rd_word[0 +: img_hbits]                       = geo_lo[rd_geo];
		end else if (i_rd_addr == fsctl_pkg::reg_frame_cnt) begin
			rd_word = i_frame_cnt;
		end else if (i_rd_addr == fsctl_pkg::reg_version) begin
			rd_word = core_version;
		end
	end

	// read data holds between reads
	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_rd_data <= '0;
		else if (i_rd_en)
			o_rd_data <= rd_word;
	end

	// shadow geometry out to the commit stage
	assign o_l1_src_w    = geo_hi[fsctl_pkg::geo_src_size];
	assign o_l1_src_h    = geo_lo[fsctl_pkg::geo_src_size];
	assign o_l1_win_left = geo_hi[fsctl_pkg::geo_win_org];
	assign o_l1_win_top  = geo_lo[fsctl_pkg::geo_win_org];
	assign o_l1_win_w    = geo_hi[fsctl_pkg::geo_win_size];
	assign o_l1_win_h    = geo_lo[fsctl_pkg::geo_win_size];
	assign o_l1_dst_left = geo_hi[fsctl_pkg::geo_dst_org];
	assign o_l1_dst_top  = geo_lo[fsctl_pkg::geo_dst_org];
	assign o_l1_dst_w    = geo_hi[fsctl_pkg::geo_dst_size];
	assign o_l1_dst_h    = geo_lo[fsctl_pkg::geo_dst_size];

	assign o_l2_src_w    = geo_hi[l2_at + fsctl_pkg::geo_src_size];
	assign o_l2_src_h    = geo_lo[l2_at + fsctl_pkg::geo_src_size];
	assign o_l2_win_left = geo_hi[l2_at + fsctl_pkg::geo_win_org];
	assign o_l2_win_top  = geo_lo[l2_at + fsctl_pkg::geo_win_org];
	assign o_l2_win_w    = geo_hi[l2_at + fsctl_pkg::geo_win_size];
	assign o_l2_win_h    = geo_lo[l2_at + fsctl_pkg::geo_win_size];
	assign o_l2_dst_left = geo_hi[l2_at + fsctl_pkg::geo_dst_org];
	assign o_l2_dst_top  = geo_lo[l2_at + fsctl_pkg::geo_dst_org];
	assign o_l2_dst_w    = geo_hi[l2_at + fsctl_pkg::geo_dst_size];
	assign o_l2_dst_h    = geo_lo[l2_at + fsctl_pkg::geo_dst_size];

endmodule

// File: logic/fsctl_top.sv
`timescale 1ns/1ns

module fsctl_top #(
	parameter int                              img_wbits    = 12,
	parameter int                              img_hbits    = 12,
	parameter logic [fsctl_pkg::data_width-1:0] core_version = 32'h0001_0000
) (
	input  logic                               o_clk,
	input  logic                               o_resetn,

	// host strobe port
	input  logic                               i_wr_en,
	input  logic [fsctl_pkg::reg_idx_width-1:0] i_wr_addr,
	input  logic [fsctl_pkg::data_width-1:0]    i_wr_data,
	input  logic                               i_rd_en,
	input  logic [fsctl_pkg::reg_idx_width-1:0] i_rd_addr,
	output logic [fsctl_pkg::data_width-1:0]    o_rd_data,

	input  logic                               i_fsync,
	output logic                               o_fsync,
	output logic                               o_soft_resetn,
	output logic                               o_order_1over2,
	output logic                               o_l1_soft_resetn,
	output logic                               o_l2_soft_resetn,

	output logic [img_wbits-1:0] o_l1_src_w, o_l1_win_left, o_l1_win_w, o_l1_dst_left, o_l1_dst_w,
	output logic [img_hbits-1:0] o_l1_src_h, o_l1_win_top, o_l1_win_h, o_l1_dst_top, o_l1_dst_h,
	output logic [img_wbits-1:0] o_l2_src_w, o_l2_win_left, o_l2_win_w, o_l2_dst_left, o_l2_dst_w,
	output logic [img_hbits-1:0] o_l2_src_h, o_l2_win_top, o_l2_win_h, o_l2_dst_top, o_l2_dst_h
);

	// shadow side of the register bank
	logic                            cfging;
	logic                            order;
	logic                            l1_run;
	logic                            l2_run;
	logic [img_wbits-1:0]            l1_src_w, l1_win_left, l1_win_w, l1_dst_left, l1_dst_w;
	logic [img_hbits-1:0]            l1_src_h, l1_win_top, l1_win_h, l1_dst_top, l1_dst_h;
	logic [img_wbits-1:0]            l2_src_w, l2_win_left, l2_win_w, l2_dst_left, l2_dst_w;
	logic [img_hbits-1:0]            l2_src_h, l2_win_top, l2_win_h, l2_dst_top, l2_dst_h;

	// frame side
	logic                            frame_strobe;
	logic [fsctl_pkg::data_width-1:0] frame_cnt;

	// --------------------------------------------------
	// host registers and frame sync, side by side
	// --------------------------------------------------
	fsctl_regbank #(
		.img_wbits(img_wbits), .img_hbits(img_hbits), .core_version(core_version)
	) regbank_i (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
		.i_frame_cnt(frame_cnt),
		.o_soft_resetn(o_soft_resetn), .o_cfging(cfging), .o_order(order),
		.o_l1_run(l1_run), .o_l2_run(l2_run),
		.o_l1_src_w(l1_src_w), .o_l1_src_h(l1_src_h),
		.o_l1_win_left(l1_win_left), .o_l1_win_top(l1_win_top),
		.o_l1_win_w(l1_win_w), .o_l1_win_h(l1_win_h),
		.o_l1_dst_left(l1_dst_left), .o_l1_dst_top(l1_dst_top),
		.o_l1_dst_w(l1_dst_w), .o_l1_dst_h(l1_dst_h),
		.o_l2_src_w(l2_src_w), .o_l2_src_h(l2_src_h),
		.o_l2_win_left(l2_win_left), .o_l2_win_top(l2_win_top),
		.o_l2_win_w(l2_win_w), .o_l2_win_h(l2_win_h),
		.o_l2_dst_left(l2_dst_left), .o_l2_dst_top(l2_dst_top),
		.o_l2_dst_w(l2_dst_w), .o_l2_dst_h(l2_dst_h)
	);

	fsctl_frame_sync sync_i (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_fsync(i_fsync),
		.o_frame_strobe(frame_strobe), .o_fsync(o_fsync), .o_frame_cnt(frame_cnt)
	);

	// --------------------------------------------------
	// frame-synchronous commit
	// --------------------------------------------------
	fsctl_commit #(.img_wbits(img_wbits), .img_hbits(img_hbits)) commit_i (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_frame_strobe(frame_strobe), .i_cfging(cfging), .i_order(order),
		.i_l1_run(l1_run), .i_l2_run(l2_run),
		.i_l1_src_w(l1_src_w), .i_l1_src_h(l1_src_h),
		.i_l1_win_left(l1_win_left), .i_l1_win_top(l1_win_top),
		.i_l1_win_w(l1_win_w), .i_l1_win_h(l1_win_h),
		.i_l1_dst_left(l1_dst_left), .i_l1_dst_top(l1_dst_top),
		.i_l1_dst_w(l1_dst_w), .i_l1_dst_h(l1_dst_h),
		.i_l2_src_w(l2_src_w), .i_l2_src_h(l2_src_h),
		.i_l2_win_left(l2_win_left), .i_l2_win_top(l2_win_top),
		.i_l2_win_w(l2_win_w), .i_l2_win_h(l2_win_h),
		.i_l2_dst_left(l2_dst_left), .i_l2_dst_top(l2_dst_top),
		.i_l2_dst_w(l2_dst_w), .i_l2_dst_h(l2_dst_h),
		.o_order_1over2(o_order_1over2),
		.o_l1_soft_resetn(o_l1_soft_resetn), .o_l2_soft_resetn(o_l2_soft_resetn),
		.o_l1_src_w(o_l1_src_w), .o_l1_src_h(o_l1_src_h),
		.o_l1_win_left(o_l1_win_left), .o_l1_win_top(o_l1_win_top),
		.o_l1_win_w(o_l1_win_w), .o_l1_win_h(o_l1_win_h),
		.o_l1_dst_left(o_l1_dst_left), .o_l1_dst_top(o_l1_dst_top),
		.o_l1_dst_w(o_l1_dst_w), .o_l1_dst_h(o_l1_dst_h),
		.o_l2_src_w(o_l2_src_w), .o_l2_src_h(o_l2_src_h),
		.o_l2_win_left(o_l2_win_left), .o_l2_win_top(o_l2_win_top),
		.o_l2_win_w(o_l2_win_w), .o_l2_win_h(o_l2_win_h),
		.o_l2_dst_left(o_l2_dst_left), .o_l2_dst_top(o_l2_dst_top),
		.o_l2_dst_w(o_l2_dst_w), .o_l2_dst_h(o_l2_dst_h)
	);

endmodule

// File: bench/fsctl_sva.sv
`timescale 1ns/1ns

module fsctl_sva #(
	parameter int img_wbits = 12,
	parameter int img_hbits = 12
) (
	input logic                                  o_clk,
	input logic                                  o_resetn,
	input logic                                  i_fsync_pulse,
	input logic [10*(img_wbits+img_hbits)+2:0]   i_committed,
	input logic                                  i_l1_soft_resetn,
	input logic                                  i_l2_soft_resetn,
	input logic [img_wbits-1:0]                  i_l1_src_w,
	input logic [img_hbits-1:0]                  i_l1_src_h,
	input logic [img_wbits-1:0]                  i_l2_src_w,
	input logic [img_hbits-1:0]                  i_l2_src_h
);

	// one pulse per rising edge, even for a long level
	fsync_single: assert property (@(posedge o_clk) disable iff (!o_resetn)
		i_fsync_pulse |=> !i_fsync_pulse)
		else $error("o_fsync was high on two cycles in a row");

	// --------------------------------------------------
	// committed state moves only with the frame pulse
	// --------------------------------------------------
	commit_on_fsync: assert property (@(posedge o_clk) disable iff (!o_resetn)
		!i_fsync_pulse |-> $stable(i_committed))
		else $error("committed outputs changed without an o_fsync pulse");

	l1_reset_size: assert property (@(posedge o_clk) disable iff (!o_resetn)
		i_l1_soft_resetn |-> (i_l1_src_w != '0 && i_l1_src_h != '0))
		else $error("layer 1 left reset with a zero committed size");

	l2_reset_size: assert property (@(posedge o_clk) disable iff (!o_resetn)
		i_l2_soft_resetn |-> (i_l2_src_w != '0 && i_l2_src_h != '0))
		else $error("layer 2 left reset with a zero committed size");

endmodule

bind fsctl_top fsctl_sva #(.img_wbits(img_wbits), .img_hbits(img_hbits)) sva_i (
	.o_clk(o_clk),
	.o_resetn(o_resetn),
	.i_fsync_pulse(o_fsync),
	.i_committed({o_order_1over2, o_l1_soft_resetn, o_l2_soft_resetn,
		o_l1_src_w, o_l1_src_h, o_l1_win_left, o_l1_win_top, o_l1_win_w, o_l1_win_h,
		o_l1_dst_left, o_l1_dst_top, o_l1_dst_w, o_l1_dst_h,
		o_l2_src_w, o_l2_src_h, o_l2_win_left, o_l2_win_top, o_l2_win_w, o_l2_win_h,
		o_l2_dst_left, o_l2_dst_top, o_l2_dst_w, o_l2_dst_h}),
	.i_l1_soft_resetn(o_l1_soft_resetn),
	.i_l2_soft_resetn(o_l2_soft_resetn),
	.i_l1_src_w(o_l1_src_w),
	.i_l1_src_h(o_l1_src_h),
	.i_l2_src_w(o_l2_src_w),
	.i_l2_src_h(o_l2_src_h)
);

// File: bench/fsctl_tb.sv
`timescale 1ns/1ns

module fsctl_tb;

	localparam int          img_wbits = 12;
	localparam int          img_hbits = 12;
	localparam logic [31:0] version   = 32'h0001_0000;
	// tests need roughly 400 cycles
	localparam int          max_cycles = 2000;
	localparam logic [31:0] geo_mask = (((32'd1 << img_wbits) - 1) << fsctl_pkg::hi_field_lsb)
		| ((32'd1 << img_hbits) - 1);
	localparam logic [31:0] ctrl_mask = (32'd1 << fsctl_pkg::ctrl_soft_resetn_bit)
		| (32'd1 << fsctl_pkg::ctrl_cfging_bit) | (32'd1 << fsctl_pkg::ctrl_order_bit)
		| (32'd1 << fsctl_pkg::ctrl_l1_run_bit) | (32'd1 << fsctl_pkg::ctrl_l2_run_bit);

	logic        o_clk = 1'b0;
	logic        o_resetn;
	logic        i_wr_en;
	logic        i_rd_en;
	logic        i_fsync;
	logic [7:0]  i_wr_addr;
	logic [7:0]  i_rd_addr;
	logic [31:0] i_wr_data;
	logic [31:0] o_rd_data;
	logic        o_fsync;
	logic        o_soft_resetn;
	logic        o_order_1over2;
	logic        o_l1_soft_resetn;
	logic        o_l2_soft_resetn;
	logic [img_wbits-1:0] o_l1_src_w, o_l1_win_left, o_l1_win_w, o_l1_dst_left, o_l1_dst_w;
	logic [img_hbits-1:0] o_l1_src_h, o_l1_win_top, o_l1_win_h, o_l1_dst_top, o_l1_dst_h;
	logic [img_wbits-1:0] o_l2_src_w, o_l2_win_left, o_l2_win_w, o_l2_dst_left, o_l2_dst_w;
	logic [img_hbits-1:0] o_l2_src_h, o_l2_win_top, o_l2_win_h, o_l2_dst_top, o_l2_dst_h;

	// model of read-back words, committed words by index and frame edges
	logic [31:0] regs [0:255];
	logic [31:0] act [0:10];
	logic        act_order;
	logic        act_srn [0:1];
	int          edges = 0;
	int          cycles = 0;
	logic [31:0] lcg_state = 32'd80;

	fsctl_top dut_i (.*);

	always #2 o_clk = ~o_clk;

	always @(posedge o_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout, run did not finish within %0d cycles", max_cycles);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] geo_word(input logic [31:0] h, input logic [31:0] v);
		return (h << fsctl_pkg::hi_field_lsb) | v;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			$display("error %s expected %h actual %h", name, exp, got);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge o_clk);
		i_wr_en   <= 1'b1;
		i_wr_addr <= addr;
		i_wr_data <= data;
		@(posedge o_clk);
		i_wr_en <= 1'b0;
		if (addr < fsctl_pkg::reg_frame_cnt)
			regs[addr] = data & (addr == fsctl_pkg::reg_ctrl ? ctrl_mask : geo_mask);
		@(negedge o_clk);
		// global soft reset follows the control bit at once
		check_val("soft reset", regs[0][fsctl_pkg::ctrl_soft_resetn_bit], o_soft_resetn);
	endtask

	task automatic read_check(input string name, input logic [7:0] addr);
		logic [31:0] exp;
		@(posedge o_clk);
		i_rd_en   <= 1'b1;
		i_rd_addr <= addr;
		@(posedge o_clk);
		i_rd_en <= 1'b0;
		// point at another index so only a held word passes
		i_rd_addr <= (addr == fsctl_pkg::reg_version) ? fsctl_pkg::reg_ctrl
			: fsctl_pkg::reg_version;
		@(negedge o_clk);
		exp = (addr == fsctl_pkg::reg_frame_cnt) ? edges : regs[addr];
		check_val(name, exp, o_rd_data);
		@(negedge o_clk);
		check_val({name, " hold"}, exp, o_rd_data);
	endtask

	task automatic write_layer(input int base);
		for (int k = 0; k < 5; k++)
			write_reg(8'(base + k), next_rand());
	endtask

	task automatic check_committed(input string name);
		logic [31:0] got [0:10];
		got[1]  = geo_word(o_l1_src_w, o_l1_src_h);
		got[2]  = geo_word(o_l1_win_left, o_l1_win_top);
		got[3]  = geo_word(o_l1_win_w, o_l1_win_h);
		got[4]  = geo_word(o_l1_dst_left, o_l1_dst_top);
		got[5]  = geo_word(o_l1_dst_w, o_l1_dst_h);
		got[6]  = geo_word(o_l2_src_w, o_l2_src_h);
		got[7]  = geo_word(o_l2_win_left, o_l2_win_top);
		got[8]  = geo_word(o_l2_win_w, o_l2_win_h);
		got[9]  = geo_word(o_l2_dst_left, o_l2_dst_top);
		got[10] = geo_word(o_l2_dst_w, o_l2_dst_h);
		for (int i = 1; i <= 10; i++)
			check_val($sformatf("%s geometry %0d", name, i), act[i], got[i]);
		check_val({name, " order"}, act_order, o_order_1over2);
		check_val({name, " l1 reset"}, act_srn[0], o_l1_soft_resetn);
		check_val({name, " l2 reset"}, act_srn[1], o_l2_soft_resetn);
	endtask

	// whole frame update unless the host holds cfging
	task automatic commit_model();
		logic run;
		int   base;
		if (regs[0][fsctl_pkg::ctrl_cfging_bit])
			return;
		act_order = regs[0][fsctl_pkg::ctrl_order_bit];
		for (int l = 0; l < 2; l++) begin
			base = l ? fsctl_pkg::reg_l2_base : fsctl_pkg::reg_l1_base;
			run  = regs[0][l ? fsctl_pkg::ctrl_l2_run_bit : fsctl_pkg::ctrl_l1_run_bit];
			for (int k = 0; k < 5; k++)
				act[base + k] = run ? regs[base + k] : 32'd0;
			act_srn[l] = run && regs[base][fsctl_pkg::hi_field_lsb +: img_wbits] != '0
				&& regs[base][0 +: img_hbits] != '0;
		end
	endtask

	task automatic run_frame(input string name, input int hold);
		@(posedge o_clk);
		i_fsync <= 1'b1;
		do
			@(negedge o_clk);
		while (!o_fsync);
		edges++;
		commit_model();
		check_committed(name);
		repeat (hold) @(posedge o_clk);
		i_fsync <= 1'b0;
		repeat (4) @(posedge o_clk);
		read_check({name, " frame count"}, fsctl_pkg::reg_frame_cnt);
	endtask

	initial begin
		o_resetn  <= 1'b0;
		i_wr_en   <= 1'b0;
		i_rd_en   <= 1'b0;
		i_fsync   <= 1'b0;
		i_wr_addr <= '0;
		i_rd_addr <= '0;
		i_wr_data <= '0;
		for (int i = 0; i < 256; i++)
			regs[i] = 32'd0;
		regs[fsctl_pkg::reg_version] = version;
		for (int i = 0; i <= 10; i++)
			act[i] = 32'd0;
		act_order  = 1'b0;
		act_srn[0] = 1'b0;
		act_srn[1] = 1'b0;
		repeat (10) @(posedge o_clk);
		o_resetn <= 1'b1;

		// --------------------------------------------------
		// reset state and register map
		// --------------------------------------------------
		@(negedge o_clk);
		check_committed("reset");
		check_val("reset fsync", 32'd0, o_fsync);
		check_val("reset soft reset", 32'd0, o_soft_resetn);
		check_val("reset read data", 32'd0, o_rd_data);
		read_check("reset version", fsctl_pkg::reg_version);
		read_check("reset frame count", fsctl_pkg::reg_frame_cnt);
		for (int i = 0; i <= 10; i++) begin
			write_reg(8'(i), next_rand());
			read_check($sformatf("readback %0d", i), 8'(i));
		end
		write_reg(fsctl_pkg::reg_version, next_rand());
		read_check("version write", fsctl_pkg::reg_version);
		write_reg(8'd12, next_rand());
		read_check("unmapped 12", 8'd12);
		read_check("unmapped 200", 8'd200);

		// geometry waits for the frame with both layers running
		write_reg(fsctl_pkg::reg_ctrl, 32'h65);
		write_layer(fsctl_pkg::reg_l1_base);
		write_layer(fsctl_pkg::reg_l2_base);
		check_committed("before fsync");
		run_frame("both running", 2);

		// host hold keeps everything including the order bit
		write_reg(fsctl_pkg::reg_ctrl, 32'h63);
		write_layer(fsctl_pkg::reg_l1_base);
		run_frame("cfging", 2);

		// layer 2 stopped and then running with zero width
		write_reg(fsctl_pkg::reg_ctrl, 32'h21);
		write_layer(fsctl_pkg::reg_l1_base);
		run_frame("l2 stopped", 2);
		write_reg(fsctl_pkg::reg_ctrl, 32'h65);
		write_reg(fsctl_pkg::reg_l2_base, next_rand() & 32'h0000_ffff);
		write_layer(fsctl_pkg::reg_l1_base);
		run_frame("l2 zero width", 2);

		// long level gives a single pulse
		run_frame("long level", 30);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: fsctl_top.f
logic/fsctl_pkg.sv
logic/fsctl_frame_sync.sv
logic/fsctl_layer_stage.sv
logic/fsctl_commit.sv
logic/fsctl_regbank.sv
logic/fsctl_top.sv
bench/fsctl_sva.sv
bench/fsctl_tb.sv

// File: Makefile
TOP = fsctl_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): fsctl_top.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fsctl_top.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f fsctl_top.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
